// File: hdl/sdram_mem_pkg.sv
// SDRAM command encoding, row and column address views, command bus type
package sdram_mem_pkg;

  // Device address and bank select widths
  localparam int ADDR_W = 11;
  localparam int BA_W   = 2;
  localparam int BANKS  = 1 << BA_W;

  // Pin order {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_e;

  // Column view, A10 doubles as the all-banks flag of PRE
  typedef struct packed {
    logic              all_banks;
    logic [ADDR_W-2:0] column;
  } sdram_col_t;

  // Same address pins, decoded as a row on ACT and as a column on RD/WR/PRE
  typedef union packed {
    logic [ADDR_W-1:0] row;
    sdram_col_t        col;
  } sdram_addr_u;

  typedef struct packed {
    sdram_cmd_e      cmd;
    logic [BA_W-1:0] ba;
    sdram_addr_u     addr;
  } sdram_cmd_bus_t;

  localparam sdram_cmd_bus_t CMD_BUS_IDLE = '{cmd: CMD_NOP, ba: '0, addr: '0};

endpackage

// File: hdl/sdram_host_pkg.sv
// Host request and read-return types of the scheduler port
package sdram_host_pkg;

  // Host word and DQ beat widths
  localparam int HOST_DATA_W = 32;
  localparam int DQ_W        = 16;

  // A10 is taken by the all-banks flag, so one column bit less than the row
  localparam int COL_W = sdram_mem_pkg::ADDR_W - 1;

  // One request moves one host word as one burst
  typedef struct packed {
    logic                             wr;
    logic [sdram_mem_pkg::BA_W-1:0]   ba;
    logic [sdram_mem_pkg::ADDR_W-1:0] row;
    logic [COL_W-1:0]                 col;
    logic [HOST_DATA_W-1:0]           wdata;
  } sdram_req_t;

  // One returning DQ beat
  typedef struct packed {
    logic            valid;
    logic [DQ_W-1:0] data;
  } sdram_rdata_t;

endpackage

// File: hdl/sdram_bank_tracker.sv
// Bank tracker: per-bank open row state and tRCD/tRAS/tRP/tRC counters
`timescale 1ns/1ps

module sdram_bank_tracker #(
  parameter int T_RCD = 2,
  parameter int T_RAS = 5,
  parameter int T_RP  = 2,
  parameter int T_RC  = 7,
  parameter int T_RFC = 8
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  input  sdram_mem_pkg::sdram_cmd_bus_t                            cmd_i,
  output logic [sdram_mem_pkg::BANKS-1:0]                          bank_open_o,
  output logic [sdram_mem_pkg::BANKS-1:0][sdram_mem_pkg::ADDR_W-1:0] open_row_o,
  output logic [sdram_mem_pkg::BANKS-1:0]                          act_ok_o,
  output logic [sdram_mem_pkg::BANKS-1:0]                          rw_ok_o,
  output logic [sdram_mem_pkg::BANKS-1:0]                          pre_ok_o
);

  // Wide enough for the largest timing value
  localparam int CNT_W = $clog2(T_RCD + T_RAS + T_RP + T_RC + T_RFC + 1);

  // Counter holds cycles left until the next command may be decided
  function automatic logic [CNT_W-1:0] cnt_next(
    input logic [CNT_W-1:0] cnt,
    input logic             load,
    input int               len
  );
    if (load)
    begin
      return (len > 1) ? CNT_W'(len - 1) : '0;
    end
    return (cnt != '0) ? cnt - 1'b1 : cnt;
  endfunction

  logic is_act;
  logic is_pre;
  logic is_ref;

  assign is_act = cmd_i.cmd == sdram_mem_pkg::CMD_ACT;
  assign is_pre = cmd_i.cmd == sdram_mem_pkg::CMD_PRE;
  assign is_ref = cmd_i.cmd == sdram_mem_pkg::CMD_REF;

  //////////////////////////////////////////////////////////////////////
  // Per-bank state
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < sdram_mem_pkg::BANKS; b++)
  begin : gen_bank
    localparam logic [sdram_mem_pkg::BA_W-1:0] BANK_ID = b;

    logic                             sel;
    logic                             act_hit;
    logic                             pre_hit;
    logic                             busy;
    logic                             open_q;
    logic [sdram_mem_pkg::ADDR_W-1:0] row_q;
    logic [CNT_W-1:0]                 rcd_q;
    logic [CNT_W-1:0]                 ras_q;
    logic [CNT_W-1:0]                 rp_q;
    logic [CNT_W-1:0]                 rc_q;

    assign sel     = cmd_i.ba == BANK_ID;
    assign act_hit = is_act && sel;
    assign pre_hit = is_pre && (sel || cmd_i.addr.col.all_banks);
    // Command on the bus now, counters load at the next edge
    assign busy    = act_hit || pre_hit || is_ref;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        open_q <= 1'b0;
        rcd_q  <= '0;
        ras_q  <= '0;
        rp_q   <= '0;
        rc_q   <= '0;
      end
      else
      begin
        if (act_hit)
        begin
          open_q <= 1'b1;
        end
        else if (pre_hit)
        begin
          open_q <= 1'b0;
        end
        rcd_q <= cnt_next(rcd_q, act_hit, T_RCD);
        ras_q <= cnt_next(ras_q, act_hit, T_RAS);
        rp_q  <= cnt_next(rp_q, pre_hit, T_RP);
        // Refresh cycles every bank internally
        rc_q  <= cnt_next(rc_q, act_hit || is_ref, is_ref ? T_RFC : T_RC);
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (act_hit)
      begin
        row_q <= cmd_i.addr.row;
      end
    end

    assign bank_open_o[b] = open_q;
    assign open_row_o[b]  = row_q;
    assign act_ok_o[b]    = (rp_q <= 1) && (rc_q <= 1) && !busy;
    assign rw_ok_o[b]     = (rcd_q <= 1) && !busy;
    assign pre_ok_o[b]    = (ras_q <= 1) && !busy;

    // Sequencer must never activate a bank that is still open
    a_act_closed : assert property (@(posedge clk_i) disable iff (!rst_ni)
      act_hit |-> !open_q);
  end

endmodule

// File: hdl/sdram_refresh_timer.sv
// Refresh timer: interval counter, pending refresh count and tRFC counter
`timescale 1ns/1ps

module sdram_refresh_timer #(
  parameter int T_RFC            = 8,
  parameter int REFRESH_INTERVAL = 780
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  sdram_mem_pkg::sdram_cmd_bus_t cmd_i,
  output logic                          refresh_due_o,
  output logic                          ref_ok_o
);

  localparam int INT_W  = $clog2(REFRESH_INTERVAL + 1);
  localparam int RFC_W  = $clog2(T_RFC + 1);
  localparam int PEND_W = 3;

  logic [INT_W-1:0]  interval_q;
  logic [PEND_W-1:0] pending_q;
  logic [RFC_W-1:0]  rfc_q;
  logic              expire;
  logic              ref_seen;

  assign ref_seen = cmd_i.cmd == sdram_mem_pkg::CMD_REF;
  assign expire   = interval_q == INT_W'(1);

  //////////////////////////////////////////////////////////////////////
  // Interval and pending count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      interval_q <= INT_W'(REFRESH_INTERVAL);
      pending_q  <= '0;
    end
    else
    begin
      interval_q <= expire ? INT_W'(REFRESH_INTERVAL) : interval_q - 1'b1;
      case ({expire, ref_seen && (pending_q != '0)})
        2'b10:   pending_q <= pending_q + 1'b1;
        2'b01:   pending_q <= pending_q - 1'b1;
        default: pending_q <= pending_q;
      endcase
    end
  end

  // REF recovery, nothing may follow within tRFC
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rfc_q <= '0;
    end
    else if (ref_seen)
    begin
      rfc_q <= (T_RFC > 1) ? RFC_W'(T_RFC - 1) : '0;
    end
    else if (rfc_q != '0)
    begin
      rfc_q <= rfc_q - 1'b1;
    end
  end

  assign refresh_due_o = pending_q != '0;
  assign ref_ok_o      = (rfc_q <= 1) && !ref_seen;

  // Sequencer falls this far behind only if refreshes are starved
  a_pend_no_ovf : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (expire && !ref_seen) |-> (pending_q != '1));

endmodule

// File: hdl/sdram_cmd_sequencer.sv
// Command sequencer: command choice, host handshake, write and read data paths
`timescale 1ns/1ps

module sdram_cmd_sequencer #(
  parameter int DQ_W        = sdram_host_pkg::DQ_W,
  parameter int HOST_DATA_W = sdram_host_pkg::HOST_DATA_W,
  parameter int CAS_LATENCY = 2
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  input  sdram_host_pkg::sdram_req_t                               req_i,
  input  logic                                                     req_valid_i,
  output logic                                                     req_ready_o,
  input  logic [sdram_mem_pkg::BANKS-1:0]                          bank_open_i,
  input  logic [sdram_mem_pkg::BANKS-1:0][sdram_mem_pkg::ADDR_W-1:0] open_row_i,
  input  logic [sdram_mem_pkg::BANKS-1:0]                          act_ok_i,
  input  logic [sdram_mem_pkg::BANKS-1:0]                          rw_ok_i,
  input  logic [sdram_mem_pkg::BANKS-1:0]                          pre_ok_i,
  input  logic                                                     refresh_due_i,
  input  logic                                                     ref_ok_i,
  output sdram_mem_pkg::sdram_cmd_bus_t                            cmd_o,
  output logic [DQ_W-1:0]                                          dq_o,
  output logic                                                     dq_oe_o,
  input  logic [DQ_W-1:0]                                          dq_i,
  output sdram_host_pkg::sdram_rdata_t                             rdata_o
);

  localparam int BURST_LEN = HOST_DATA_W / DQ_W;
  localparam int BEAT_W    = $clog2(BURST_LEN) + 1;
  localparam int RD_PIPE_W = CAS_LATENCY + BURST_LEN - 1;
  // Read valid window as seen one cycle after the RD decision
  localparam logic [RD_PIPE_W-1:0] RD_WINDOW =
    RD_PIPE_W'({BURST_LEN{1'b1}}) << (CAS_LATENCY - 1);

  sdram_mem_pkg::sdram_cmd_bus_t cmd_d;
  sdram_mem_pkg::sdram_cmd_bus_t cmd_q;
  logic                          ready_q;
  logic                          issue_rd;
  logic                          issue_wr;
  logic [HOST_DATA_W-1:0]        wr_data_q;
  logic [BEAT_W-1:0]             wr_left_q;
  logic                          dq_oe_q;
  logic [RD_PIPE_W-1:0]          rd_pipe_q;
  logic                          rd_valid_q;
  logic                          req_act;
  logic                          row_hit;
  logic                          req_bank_open;
  logic                          wr_busy;
  logic                          rd_busy;
  logic                          rd_path_free;
  logic                          wr_path_free;
  logic                          pre_quiet;
  logic                          all_pre_ok;

  //////////////////////////////////////////////////////////////////////
  // Request and bus status
  //////////////////////////////////////////////////////////////////////

  // Request already served while ready is high
  assign req_act       = req_valid_i && !ready_q;
  assign req_bank_open = bank_open_i[req_i.ba];
  assign row_hit       = req_bank_open && (open_row_i[req_i.ba] == req_i.row);

  // Write beats still to go after this cycle
  assign wr_busy      = dq_oe_q && (wr_left_q != '0);
  // Earlier read burst not yet BURST_LEN cycles old
  assign rd_busy      = |(rd_pipe_q >> CAS_LATENCY);
  assign rd_path_free = !wr_busy && !rd_busy;
  // Bus turnaround, WR waits until all read beats are back
  assign wr_path_free = !wr_busy && (rd_pipe_q == '0) && !rd_valid_q;
  assign pre_quiet    = !dq_oe_q && !rd_busy;
  assign all_pre_ok   = &(pre_ok_i | ~bank_open_i);

  //////////////////////////////////////////////////////////////////////
  // Command choice
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    cmd_d     = cmd_q;
    cmd_d.cmd = sdram_mem_pkg::CMD_NOP;
    issue_rd  = 1'b0;
    issue_wr  = 1'b0;

    // Nothing at all during tRFC
    if (ref_ok_i)
    begin
      if (refresh_due_i)
      begin
        if (|bank_open_i)
        begin
          if (all_pre_ok && pre_quiet)
          begin
            cmd_d.cmd                = sdram_mem_pkg::CMD_PRE;
            cmd_d.addr.col.all_banks = 1'b1;
          end
        end
        else if (&act_ok_i)
        begin
          cmd_d.cmd = sdram_mem_pkg::CMD_REF;
        end
      end
      else if (req_act)
      begin
        if (row_hit)
        begin
          if (rw_ok_i[req_i.ba] && (req_i.wr ? wr_path_free : rd_path_free))
          begin
            cmd_d.cmd                = req_i.wr ? sdram_mem_pkg::CMD_WR : sdram_mem_pkg::CMD_RD;
            cmd_d.ba                 = req_i.ba;
            cmd_d.addr.col.all_banks = 1'b0;
            cmd_d.addr.col.column    = req_i.col;
            issue_wr                 = req_i.wr;
            issue_rd                 = !req_i.wr;
          end
        end
        else if (req_bank_open)
        begin
          // Row conflict
          if (pre_ok_i[req_i.ba] && pre_quiet)
          begin
            cmd_d.cmd                = sdram_mem_pkg::CMD_PRE;
            cmd_d.ba                 = req_i.ba;
            cmd_d.addr.col.all_banks = 1'b0;
          end
        end
        else if (act_ok_i[req_i.ba])
        begin
          cmd_d.cmd      = sdram_mem_pkg::CMD_ACT;
          cmd_d.ba       = req_i.ba;
          cmd_d.addr.row = req_i.row;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cmd_q   <= sdram_mem_pkg::CMD_BUS_IDLE;
      ready_q <= 1'b0;
    end
    else
    begin
      cmd_q   <= cmd_d;
      ready_q <= issue_rd || issue_wr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write data, low beat first
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      dq_oe_q   <= 1'b0;
      wr_left_q <= '0;
    end
    else if (issue_wr)
    begin
      dq_oe_q   <= 1'b1;
      wr_left_q <= BEAT_W'(BURST_LEN - 1);
    end
    else if (dq_oe_q)
    begin
      if (wr_left_q == '0)
      begin
        dq_oe_q <= 1'b0;
      end
      else
      begin
        wr_left_q <= wr_left_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_wr)
    begin
      wr_data_q <= req_i.wdata;
    end
    else if (dq_oe_q)
    begin
      wr_data_q <= wr_data_q >> DQ_W;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read return window
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_pipe_q  <= '0;
      rd_valid_q <= 1'b0;
    end
    else
    begin
      // Back-to-back windows overlap in flight
      rd_pipe_q  <= (rd_pipe_q >> 1) | (issue_rd ? RD_WINDOW : '0);
      rd_valid_q <= rd_pipe_q[0];
    end
  end

  assign cmd_o       = cmd_q;
  assign req_ready_o = ready_q;
  assign dq_o        = wr_data_q[DQ_W-1:0];
  assign dq_oe_o     = dq_oe_q;
  assign rdata_o     = '{valid: rd_valid_q, data: dq_i};

  // Never drive DQ while read data is returning
  a_dq_dir : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(dq_oe_q && rd_valid_q));

endmodule

// File: hdl/sdram_scheduler_top.sv
// Scheduler top level: bank tracker, refresh timer and command sequencer
`timescale 1ns/1ps

module sdram_scheduler_top #(
  parameter int DQ_W             = sdram_host_pkg::DQ_W,
  parameter int HOST_DATA_W      = sdram_host_pkg::HOST_DATA_W,
  parameter int T_RCD            = 2,
  parameter int T_RAS            = 5,
  parameter int T_RP             = 2,
  parameter int T_RC             = 7,
  parameter int T_RFC            = 8,
  parameter int CAS_LATENCY      = 2,
  parameter int REFRESH_INTERVAL = 780
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  sdram_host_pkg::sdram_req_t    req_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  output sdram_mem_pkg::sdram_cmd_bus_t cmd_o,
  output logic [DQ_W-1:0]               dq_o,
  output logic                          dq_oe_o,
  input  logic [DQ_W-1:0]               dq_i,
  output sdram_host_pkg::sdram_rdata_t  rdata_o
);

  logic [sdram_mem_pkg::BANKS-1:0]                            bank_open;
  logic [sdram_mem_pkg::BANKS-1:0][sdram_mem_pkg::ADDR_W-1:0] open_row;
  logic [sdram_mem_pkg::BANKS-1:0]                            act_ok;
  logic [sdram_mem_pkg::BANKS-1:0]                            rw_ok;
  logic [sdram_mem_pkg::BANKS-1:0]                            pre_ok;
  logic                                                       refresh_due;
  logic                                                       ref_ok;

  sdram_bank_tracker #(
    .T_RCD (T_RCD),
    .T_RAS (T_RAS),
    .T_RP  (T_RP),
    .T_RC  (T_RC),
    .T_RFC (T_RFC)
  ) u_bank_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd_o),
    .bank_open_o (bank_open),
    .open_row_o  (open_row),
    .act_ok_o    (act_ok),
    .rw_ok_o     (rw_ok),
    .pre_ok_o    (pre_ok)
  );

  sdram_refresh_timer #(
    .T_RFC            (T_RFC),
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) u_refresh_timer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd_o),
    .refresh_due_o (refresh_due),
    .ref_ok_o      (ref_ok)
  );

  sdram_cmd_sequencer #(
    .DQ_W        (DQ_W),
    .HOST_DATA_W (HOST_DATA_W),
    .CAS_LATENCY (CAS_LATENCY)
  ) u_cmd_sequencer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .bank_open_i   (bank_open),
    .open_row_i    (open_row),
    .act_ok_i      (act_ok),
    .rw_ok_i       (rw_ok),
    .pre_ok_i      (pre_ok),
    .refresh_due_i (refresh_due),
    .ref_ok_i      (ref_ok),
    .cmd_o         (cmd_o),
    .dq_o          (dq_o),
    .dq_oe_o       (dq_oe_o),
    .dq_i          (dq_i),
    .rdata_o       (rdata_o)
  );

endmodule

// File: sim/sdram_cmd_checker.sv
// Checker: open-row model, command timing, write data and read window compare
`timescale 1ns/1ps

module sdram_cmd_checker #(
  parameter int DQ_W             = 16,
  parameter int HOST_DATA_W      = 32,
  parameter int T_RCD            = 2,
  parameter int T_RAS            = 5,
  parameter int T_RP             = 2,
  parameter int T_RC             = 7,
  parameter int T_RFC            = 8,
  parameter int CAS_LATENCY      = 2,
  parameter int REFRESH_INTERVAL = 780
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  sdram_host_pkg::sdram_req_t    req_i,
  input  logic                          req_valid_i,
  input  logic [1:0]                    exp_class_i,
  input  logic                          req_ready_i,
  input  sdram_mem_pkg::sdram_cmd_bus_t cmd_i,
  input  logic [DQ_W-1:0]               dq_out_i,
  input  logic                          dq_oe_i,
  input  logic [DQ_W-1:0]               dq_in_i,
  input  sdram_host_pkg::sdram_rdata_t  rdata_i,
  output int                            ref_count_o
);

  localparam int BURST_LEN = HOST_DATA_W / DQ_W;
  localparam int BANKS     = sdram_mem_pkg::BANKS;

  bit                               model_open [BANKS];
  logic [sdram_mem_pkg::ADDR_W-1:0] model_row  [BANKS];
  int                               last_act   [BANKS];
  int                               last_pre   [BANKS];
  logic [DQ_W-1:0]                  wr_beats   [$];
  bit                               rd_expect  [int];
  int  cycle;
  int  last_ref;
  int  errors;
  int  refs;
  int  rd_beats_exp;
  int  rd_beats_seen;
  // Commands seen since the last RD or WR
  bit  seen_act;
  bit  seen_pre;
  bit  seen_ref;

  initial
  begin
    for (int b = 0; b < BANKS; b++)
    begin
      model_open[b] = 1'b0;
      last_act[b]   = -1000;
      last_pre[b]   = -1000;
    end
    cycle = 0;
    last_ref = -1000;
    errors = 0;
    refs = 0;
    rd_beats_exp = 0;
    rd_beats_seen = 0;
  end

  assign ref_count_o = refs;

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    $display("Fail %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cycle);
    errors++;
  endtask

  task automatic report_text(input string msg);
    $display("Error at cycle %0d: %s", cycle, msg);
    errors++;
  endtask

  task automatic check_spacing(input int since, input int min, input string what);
    if (cycle - since < min)
      report_text($sformatf("%s spacing %0d below %0d", what, cycle - since, min));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Command bus against the open-row model
  //////////////////////////////////////////////////////////////////////

  task automatic check_cmd();
    int b;
    int observed;
    b = int'(cmd_i.ba);
    if (cmd_i.cmd != sdram_mem_pkg::CMD_NOP)
      check_spacing(last_ref, T_RFC, "REF to command");
    if (req_ready_i && cmd_i.cmd != sdram_mem_pkg::CMD_RD
        && cmd_i.cmd != sdram_mem_pkg::CMD_WR)
      report_text("ready without a RD or WR command");
    case (cmd_i.cmd)
      sdram_mem_pkg::CMD_ACT:
      begin
        if (model_open[b])
          report_text("ACT to a bank that is already open");
        check_spacing(last_pre[b], T_RP, "PRE to ACT");
        check_spacing(last_act[b], T_RC, "ACT to ACT");
        if (cmd_i.ba != req_i.ba)
          report_value("cmd_o.ba", cmd_i.ba, req_i.ba);
        if (cmd_i.addr.row != req_i.row)
          report_value("cmd_o.addr.row", cmd_i.addr.row, req_i.row);
        model_open[b] = 1'b1;
        model_row[b]  = cmd_i.addr.row;
        last_act[b]   = cycle;
        seen_act      = 1'b1;
      end
      sdram_mem_pkg::CMD_PRE:
      begin
        for (int k = 0; k < BANKS; k++)
        begin
          if (cmd_i.addr.col.all_banks || k == b)
          begin
            if (model_open[k])
              check_spacing(last_act[k], T_RAS, "ACT to PRE");
            model_open[k] = 1'b0;
            last_pre[k]   = cycle;
          end
        end
        if (cmd_i.addr.col.all_banks)
          seen_ref = 1'b1;
        else
          seen_pre = 1'b1;
      end
      sdram_mem_pkg::CMD_REF:
      begin
        for (int k = 0; k < BANKS; k++)
          if (model_open[k])
            report_text($sformatf("REF while bank %0d is open", k));
        if (cycle - ((refs == 0) ? 0 : last_ref) > REFRESH_INTERVAL + 32)
          report_text("REF came later than one refresh interval");
        for (int k = 0; k < BANKS; k++)
          last_act[k] = cycle - T_RC + T_RFC;
        refs++;
        last_ref = cycle;
        seen_ref = 1'b1;
      end
      sdram_mem_pkg::CMD_RD, sdram_mem_pkg::CMD_WR:
      begin
        if (!req_ready_i)
          report_text("RD or WR without the ready pulse");
        if (!req_valid_i)
          report_text("RD or WR without a pending request");
        if (cmd_i.ba != req_i.ba)
          report_value("cmd_o.ba", cmd_i.ba, req_i.ba);
        if (!model_open[b])
          report_text("RD or WR to a closed bank");
        else if (model_row[b] != req_i.row)
          report_value("open row", model_row[b], req_i.row);
        if (cmd_i.addr.col.column != req_i.col)
          report_value("cmd_o.addr.col.column", cmd_i.addr.col.column, req_i.col);
        // No auto-precharge, A10 stays low on RD and WR
        if (cmd_i.addr.col.all_banks)
          report_value("cmd_o.addr.col.all_banks", cmd_i.addr.col.all_banks, 1'b0);
        if ((cmd_i.cmd == sdram_mem_pkg::CMD_WR) != req_i.wr)
          report_value("cmd_o.cmd", cmd_i.cmd,
                       req_i.wr ? sdram_mem_pkg::CMD_WR : sdram_mem_pkg::CMD_RD);
        check_spacing(last_act[b], T_RCD, "ACT to RD/WR");
        observed = seen_act ? (seen_pre ? 2 : 1) : 0;
        // A refresh in between closes the row, so the file class no longer holds
        if (!seen_ref && observed != int'(exp_class_i))
          report_value("row class", observed, exp_class_i);
        if (cmd_i.cmd == sdram_mem_pkg::CMD_WR)
        begin
          for (int k = 0; k < BURST_LEN; k++)
            wr_beats.push_back(req_i.wdata[k*DQ_W +: DQ_W]);
        end
        else
        begin
          for (int k = 0; k < BURST_LEN; k++)
            rd_expect[cycle + CAS_LATENCY + k] = 1'b1;
          rd_beats_exp += BURST_LEN;
        end
        seen_act = 1'b0;
        seen_pre = 1'b0;
        seen_ref = 1'b0;
      end
      default:
      begin
      end
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Data paths
  //////////////////////////////////////////////////////////////////////

  task automatic check_data();
    logic [DQ_W-1:0] exp_beat;
    bit              exp_valid;
    if (wr_beats.size() > 0)
    begin
      exp_beat = wr_beats.pop_front();
      if (!dq_oe_i)
        report_text("dq_oe_o low during a write burst");
      else if (dq_out_i != exp_beat)
        report_value("dq_o", dq_out_i, exp_beat);
    end
    else if (dq_oe_i)
    begin
      report_text("dq_oe_o high with no write burst");
    end
    exp_valid = rd_expect.exists(cycle);
    if (exp_valid)
      rd_expect.delete(cycle);
    if (rdata_i.valid != exp_valid)
      report_value("rdata_o.valid", rdata_i.valid, exp_valid);
    if (rdata_i.valid)
    begin
      rd_beats_seen++;
      if (rdata_i.data != dq_in_i)
        report_value("rdata_o.data", rdata_i.data, dq_in_i);
    end
  endtask

  // Sample away from the rising edge where inputs change
  always @(negedge clk_i)
  begin
    if (rst_ni)
    begin
      cycle++;
      check_cmd();
      check_data();
    end
  end

  task automatic final_check(output int count);
    if (rd_beats_seen != rd_beats_exp)
      report_value("read beat count", rd_beats_seen, rd_beats_exp);
    if (wr_beats.size() != 0)
      report_text("write burst still incomplete at the end");
    if (refs < cycle / REFRESH_INTERVAL - 1)
      report_value("refresh count", refs, cycle / REFRESH_INTERVAL - 1);
    count = errors;
  endtask

endmodule

// File: sim/tb_sdram_scheduler.sv
// Testbench top: clock, reset, test file reading, request driving and DQ stimulus
`timescale 1ns/1ps

module tb_sdram_scheduler;

  localparam int DQ_W             = 16;
  localparam int HOST_DATA_W      = 32;
  localparam int T_RCD            = 2;
  localparam int T_RAS            = 5;
  localparam int T_RP             = 2;
  localparam int T_RC             = 7;
  localparam int T_RFC            = 8;
  localparam int CAS_LATENCY      = 2;
  // Short interval so the run sees several refreshes
  localparam int REFRESH_INTERVAL = 300;
  localparam int READY_TIMEOUT    = 200;

  logic                          clk;
  logic                          rst_n;
  sdram_host_pkg::sdram_req_t    req;
  logic                          req_valid;
  logic                          req_ready;
  sdram_mem_pkg::sdram_cmd_bus_t cmd;
  logic [DQ_W-1:0]               dq_out;
  logic                          dq_oe;
  logic [DQ_W-1:0]               dq_in;
  sdram_host_pkg::sdram_rdata_t  rdata;
  logic [1:0]                    exp_class;
  logic [31:0]                   lcg_state = 32'ha9be;
  int                            tb_errors;
  int                            ref_count;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Read data seen on the DQ pins
  always @(posedge clk)
  begin
    lcg_state <= lcg_next(lcg_state);
    dq_in     <= lcg_state[23:8];
  end

  sdram_scheduler_top #(
    .DQ_W (DQ_W), .HOST_DATA_W (HOST_DATA_W), .T_RCD (T_RCD), .T_RAS (T_RAS),
    .T_RP (T_RP), .T_RC (T_RC), .T_RFC (T_RFC), .CAS_LATENCY (CAS_LATENCY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) dut0 (
    .clk_i (clk), .rst_ni (rst_n), .req_i (req), .req_valid_i (req_valid),
    .req_ready_o (req_ready), .cmd_o (cmd), .dq_o (dq_out), .dq_oe_o (dq_oe),
    .dq_i (dq_in), .rdata_o (rdata)
  );

  sdram_cmd_checker #(
    .DQ_W (DQ_W), .HOST_DATA_W (HOST_DATA_W), .T_RCD (T_RCD), .T_RAS (T_RAS),
    .T_RP (T_RP), .T_RC (T_RC), .T_RFC (T_RFC), .CAS_LATENCY (CAS_LATENCY),
    .REFRESH_INTERVAL (REFRESH_INTERVAL)
  ) chk0 (
    .clk_i (clk), .rst_ni (rst_n), .req_i (req), .req_valid_i (req_valid),
    .exp_class_i (exp_class), .req_ready_i (req_ready), .cmd_i (cmd),
    .dq_out_i (dq_out), .dq_oe_i (dq_oe), .dq_in_i (dq_in), .rdata_i (rdata),
    .ref_count_o (ref_count)
  );

  initial
  begin
    int               fd;
    int               n;
    int               wait_cnt;
    int               total;
    string            line;
    reg [8*8-1:0]     op;
    reg [8*8-1:0]     cls;
    logic [31:0]      ba;
    logic [31:0]      row;
    logic [31:0]      col;
    logic [31:0]      wdata;

    tb_errors = 0;
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    dq_in     = '0;
    exp_class = 2'd0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    fd = $fopen("sim/sdram_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test file sim/sdram_tests.txt");
      tb_errors++;
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        if (line.len() < 2 || line[0] == "#")
        begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %h %h %s", op, ba, row, col, wdata, cls);
        if (n != 6)
        begin
          $display("Malformed test line: %s", line);
          tb_errors++;
          continue;
        end
        req.wr    <= (op == "wr");
        req.ba    <= ba[sdram_mem_pkg::BA_W-1:0];
        req.row   <= row[sdram_mem_pkg::ADDR_W-1:0];
        req.col   <= col[sdram_host_pkg::COL_W-1:0];
        req.wdata <= wdata;
        req_valid <= 1'b1;
        if (cls == "hit")
          exp_class <= 2'd0;
        else if (cls == "closed")
          exp_class <= 2'd1;
        else
          exp_class <= 2'd2;

        // Host holds the request until ready is seen on an edge
        wait_cnt = 0;
        do
        begin
          @(posedge clk);
          wait_cnt++;
        end
        while (!req_ready && wait_cnt < READY_TIMEOUT);
        if (!req_ready)
        begin
          $display("Timeout: no ready for request %s", line);
          tb_errors++;
        end
      end
      $fclose(fd);
    end
    req_valid <= 1'b0;

    // Idle until at least two refreshes have gone by
    wait_cnt = 0;
    while (ref_count < 2 && wait_cnt < 4 * REFRESH_INTERVAL)
    begin
      @(posedge clk);
      wait_cnt++;
    end
    if (ref_count < 2)
    begin
      $display("Timeout: fewer than two refreshes seen while idle");
      tb_errors++;
    end

    chk0.final_check(total);
    $display("Errors: checker %0d, testbench %0d", total, tb_errors);
    if (total + tb_errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: sim/sdram_tests.txt
# op bank row col wdata class
# op is rd or wr; bank, row, col and wdata in hex; class is hit, closed or conflict
wr 0 010 004 a5a51234 closed
rd 0 010 004 00000000 hit
wr 0 010 008 0badf00d hit
rd 1 022 010 00000000 closed
rd 1 022 014 00000000 hit
rd 1 022 018 00000000 hit
wr 1 033 000 cafe0001 conflict
rd 1 033 000 00000000 hit
wr 2 100 3ff 12345678 closed
rd 0 011 020 00000000 conflict
wr 3 7ff 001 deadbeef closed
rd 3 7ff 002 00000000 hit
rd 2 100 3ff 00000000 hit
wr 2 155 030 55aa55aa conflict
rd 0 011 024 00000000 hit
rd 3 000 040 00000000 conflict
wr 0 011 028 f00dcafe hit
rd 0 011 028 00000000 hit

// File: sdram_scheduler_top.f
hdl/sdram_mem_pkg.sv
hdl/sdram_host_pkg.sv
hdl/sdram_bank_tracker.sv
hdl/sdram_refresh_timer.sv
hdl/sdram_cmd_sequencer.sv
hdl/sdram_scheduler_top.sv
sim/sdram_cmd_checker.sv
sim/tb_sdram_scheduler.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sdram_scheduler
FILELIST  = sdram_scheduler_top.f
PASS_TEXT = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
